// File: include/dxa_smem_settings.svh
// Shared memory settings

`ifndef DXA_SMEM_SETTINGS_SVH
`define DXA_SMEM_SETTINGS_SVH

// Wide word size in bytes as seen by the copy engine
`define DXA_SMEM_WORD_BYTES 16

// Narrow word size in bytes as seen by the load/store unit
`define SMEM_WORD_BYTES 4

// Number of narrow words in the single shared-memory bank
`define SMEM_DEPTH 1024

// Request tag width, common to both ports
`define SMEM_TAG_W 4

// Narrow lanes per wide word
`define DXA_LANES 4

// Data widths in bits derived from the byte sizes
`define SMEM_DATA_W (`SMEM_WORD_BYTES * 8)
`define DXA_DATA_W (`DXA_SMEM_WORD_BYTES * 8)

`endif

// File: verilog/dxa_smem_pkg.sv
// Shared memory types

`include "dxa_smem_settings.svh"

package dxa_smem_pkg;

    // One narrow word and its byte enables
    typedef logic [`SMEM_DATA_W-1:0] smem_data_t;
    typedef logic [`SMEM_WORD_BYTES-1:0] smem_byteen_t;

    // Narrow word address into the bank
    typedef logic [$clog2(`SMEM_DEPTH)-1:0] smem_addr_t;

    // One wide word and its byte enables
    typedef logic [`DXA_DATA_W-1:0] dxa_data_t;
    typedef logic [`DXA_SMEM_WORD_BYTES-1:0] dxa_byteen_t;

    // Wide line address, the narrow address without the lane bits
    typedef logic [$clog2(`SMEM_DEPTH)-$clog2(`DXA_LANES)-1:0] dxa_addr_t;

    // Selects one narrow lane inside a wide word
    typedef logic [$clog2(`DXA_LANES)-1:0] lane_idx_t;

    // Tag echoed back with every read response
    typedef logic [`SMEM_TAG_W-1:0] mem_tag_t;

    // Requester that issued a read, kept in order by the arbiter
    typedef enum logic {
        owner_dxa,
        owner_lsu
    } port_owner_e;

endpackage

// File: verilog/dxa_smem_downsize.sv
// Wide to narrow request downsizer

`include "dxa_smem_settings.svh"

module dxa_smem_downsize import dxa_smem_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Wide request from the copy engine
    input  logic         dxa_req_valid,
    input  logic         dxa_req_rw,
    input  dxa_addr_t    dxa_req_addr,
    input  dxa_byteen_t  dxa_req_byteen,
    input  dxa_data_t    dxa_req_data,
    input  mem_tag_t     dxa_req_tag,
    output logic         dxa_req_ready,

    // Wide response to the copy engine
    output logic         dxa_rsp_valid,
    output dxa_data_t    dxa_rsp_data,
    output mem_tag_t     dxa_rsp_tag,
    input  logic         dxa_rsp_ready,

    // Narrow request toward the arbiter
    output logic         ds_req_valid,
    output logic         ds_req_rw,
    output smem_addr_t   ds_req_addr,
    output smem_byteen_t ds_req_byteen,
    output smem_data_t   ds_req_data,
    output mem_tag_t     ds_req_tag,
    input  logic         ds_req_ready,

    // Narrow response from the arbiter
    input  logic         ds_rsp_valid,
    input  smem_data_t   ds_rsp_data,
    input  mem_tag_t     ds_rsp_tag,
    output logic         ds_rsp_ready
);

    smem_data_t   [`DXA_LANES-1:0] req_data_lanes;
    smem_byteen_t [`DXA_LANES-1:0] req_byteen_lanes;
    smem_data_t   [`DXA_LANES-1:0] rsp_data_lanes;
    logic         [`DXA_LANES-1:0] lane_active;
    lane_idx_t                     req_lane;
    lane_idx_t                     rsp_lane;
    logic                          rd_pending;
    logic                          rd_blocked;

    assign req_data_lanes   = dxa_req_data;
    assign req_byteen_lanes = dxa_req_byteen;

    // A lane is active when any of its byte enables is set
    always_comb begin
        for (int i = 0; i < `DXA_LANES; i++) begin
            lane_active[i] = |req_byteen_lanes[i];
        end
    end

    // Highest active lane wins, only one is expected per request
    always_comb begin
        req_lane = '0;
        for (int i = 0; i < `DXA_LANES; i++) begin
            if (lane_active[i]) begin
                req_lane = lane_idx_t'(i);
            end
        end
    end

    // A second read waits until the first one has returned
    assign rd_blocked = rd_pending && !dxa_req_rw;

    assign ds_req_valid  = dxa_req_valid && !rd_blocked;
    assign ds_req_rw     = dxa_req_rw;
    assign ds_req_addr   = {dxa_req_addr, req_lane};
    assign ds_req_byteen = req_byteen_lanes[req_lane];
    assign ds_req_data   = req_data_lanes[req_lane];
    assign ds_req_tag    = dxa_req_tag;
    assign dxa_req_ready = ds_req_ready && !rd_blocked;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            if (ds_rsp_valid && ds_rsp_ready) begin
                rd_pending <= 1'b0;
            end
            if (dxa_req_valid && dxa_req_ready && !dxa_req_rw) begin
                rd_pending <= 1'b1;
            end
        end
    end

    // Lane of the outstanding read
    always_ff @(posedge clk) begin
        if (dxa_req_valid && dxa_req_ready && !dxa_req_rw) begin
            rsp_lane <= req_lane;
        end
    end

    // Narrow data goes back into its lane, the others read as zero
    always_comb begin
        rsp_data_lanes = '0;
        rsp_data_lanes[rsp_lane] = ds_rsp_data;
    end

    assign dxa_rsp_valid = ds_rsp_valid;
    assign dxa_rsp_data  = rsp_data_lanes;
    assign dxa_rsp_tag   = ds_rsp_tag;
    assign ds_rsp_ready  = dxa_rsp_ready;

endmodule

// File: verilog/smem_arbiter.sv
// Two port round-robin arbiter

module smem_arbiter import dxa_smem_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Downsized copy engine port
    input  logic         ds_req_valid,
    input  logic         ds_req_rw,
    input  smem_addr_t   ds_req_addr,
    input  smem_byteen_t ds_req_byteen,
    input  smem_data_t   ds_req_data,
    input  mem_tag_t     ds_req_tag,
    output logic         ds_req_ready,
    output logic         ds_rsp_valid,
    output smem_data_t   ds_rsp_data,
    output mem_tag_t     ds_rsp_tag,
    input  logic         ds_rsp_ready,

    // Load/store unit port
    input  logic         lsu_req_valid,
    input  logic         lsu_req_rw,
    input  smem_addr_t   lsu_req_addr,
    input  smem_byteen_t lsu_req_byteen,
    input  smem_data_t   lsu_req_data,
    input  mem_tag_t     lsu_req_tag,
    output logic         lsu_req_ready,
    output logic         lsu_rsp_valid,
    output smem_data_t   lsu_rsp_data,
    output mem_tag_t     lsu_rsp_tag,
    input  logic         lsu_rsp_ready,

    // Merged stream to the bank
    output logic         mem_req_valid,
    output logic         mem_req_rw,
    output smem_addr_t   mem_req_addr,
    output smem_byteen_t mem_req_byteen,
    output smem_data_t   mem_req_data,
    output mem_tag_t     mem_req_tag,
    input  logic         mem_req_ready,
    input  logic         mem_rsp_valid,
    input  smem_data_t   mem_rsp_data,
    input  mem_tag_t     mem_rsp_tag,
    output logic         mem_rsp_ready
);

    logic        prio_lsu;
    logic        grant_ds;
    logic        grant_lsu;
    logic        q_full;
    logic        req_fire;
    logic        push;
    logic        pop;
    port_owner_e owner_q [2];
    port_owner_e head_owner;
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  q_count;

    // The port that won last has the lower priority on a tie
    assign grant_ds  = ds_req_valid && (!lsu_req_valid || !prio_lsu);
    assign grant_lsu = lsu_req_valid && (!ds_req_valid || prio_lsu);

    assign q_full        = (q_count == 2'd2);
    assign mem_req_valid = (ds_req_valid || lsu_req_valid) && !q_full;
    assign ds_req_ready  = mem_req_ready && grant_ds && !q_full;
    assign lsu_req_ready = mem_req_ready && grant_lsu && !q_full;

    assign mem_req_rw     = grant_lsu ? lsu_req_rw     : ds_req_rw;
    assign mem_req_addr   = grant_lsu ? lsu_req_addr   : ds_req_addr;
    assign mem_req_byteen = grant_lsu ? lsu_req_byteen : ds_req_byteen;
    assign mem_req_data   = grant_lsu ? lsu_req_data   : ds_req_data;
    assign mem_req_tag    = grant_lsu ? lsu_req_tag    : ds_req_tag;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign push     = req_fire && !mem_req_rw;
    assign pop      = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_lsu <= 1'b0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            q_count  <= '0;
        end else begin
            if (req_fire) begin
                prio_lsu <= grant_ds;
            end
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            if (push && !pop) begin
                q_count <= q_count + 2'd1;
            end else if (pop && !push) begin
                q_count <= q_count - 2'd1;
            end
        end
    end

    // Owners are recorded in the order the bank sees the reads
    always_ff @(posedge clk) begin
        if (push) begin
            owner_q[wr_ptr] <= grant_lsu ? owner_lsu : owner_dxa;
        end
    end

    assign head_owner = owner_q[rd_ptr];

    assign ds_rsp_valid  = mem_rsp_valid && (head_owner == owner_dxa);
    assign lsu_rsp_valid = mem_rsp_valid && (head_owner == owner_lsu);
    assign ds_rsp_data   = mem_rsp_data;
    assign ds_rsp_tag    = mem_rsp_tag;
    assign lsu_rsp_data  = mem_rsp_data;
    assign lsu_rsp_tag   = mem_rsp_tag;
    assign mem_rsp_ready = (head_owner == owner_lsu) ? lsu_rsp_ready : ds_rsp_ready;

endmodule

// File: verilog/smem_bank.sv
// Shared memory bank

`include "dxa_smem_settings.svh"

module smem_bank import dxa_smem_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Request
    input  logic         mem_req_valid,
    input  logic         mem_req_rw,
    input  smem_addr_t   mem_req_addr,
    input  smem_byteen_t mem_req_byteen,
    input  smem_data_t   mem_req_data,
    input  mem_tag_t     mem_req_tag,
    output logic         mem_req_ready,

    // Read response
    output logic         mem_rsp_valid,
    output smem_data_t   mem_rsp_data,
    output mem_tag_t     mem_rsp_tag,
    input  logic         mem_rsp_ready
);

    smem_data_t mem [`SMEM_DEPTH];
    logic       req_fire;
    logic       rd_fire;
    logic       wr_fire;
    logic       rsp_fire;

    // A new request is taken only when the response slot is free or leaving
    assign mem_req_ready = !mem_rsp_valid || mem_rsp_ready;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign rd_fire  = req_fire && !mem_req_rw;
    assign wr_fire  = req_fire && mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    // Byte-granular write, committed at the accepting edge
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < `SMEM_WORD_BYTES; b++) begin
                if (mem_req_byteen[b]) begin
                    mem[mem_req_addr][b*8 +: 8] <= mem_req_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            mem_rsp_valid <= 1'b1;
        end else if (rsp_fire) begin
            mem_rsp_valid <= 1'b0;
        end
    end

    // Read data and tag stay put until the response is taken
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            mem_rsp_data <= mem[mem_req_addr];
            mem_rsp_tag  <= mem_req_tag;
        end
    end

endmodule

// File: verilog/dxa_smem_top.sv
// Tensor copy shared memory top

module dxa_smem_top import dxa_smem_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Copy engine port
    input  logic         dxa_req_valid,
    input  logic         dxa_req_rw,
    input  dxa_addr_t    dxa_req_addr,
    input  dxa_byteen_t  dxa_req_byteen,
    input  dxa_data_t    dxa_req_data,
    input  mem_tag_t     dxa_req_tag,
    output logic         dxa_req_ready,
    output logic         dxa_rsp_valid,
    output dxa_data_t    dxa_rsp_data,
    output mem_tag_t     dxa_rsp_tag,
    input  logic         dxa_rsp_ready,

    // Load/store unit port
    input  logic         lsu_req_valid,
    input  logic         lsu_req_rw,
    input  smem_addr_t   lsu_req_addr,
    input  smem_byteen_t lsu_req_byteen,
    input  smem_data_t   lsu_req_data,
    input  mem_tag_t     lsu_req_tag,
    output logic         lsu_req_ready,
    output logic         lsu_rsp_valid,
    output smem_data_t   lsu_rsp_data,
    output mem_tag_t     lsu_rsp_tag,
    input  logic         lsu_rsp_ready
);

    // Downsizer to arbiter
    logic         ds_req_valid;
    logic         ds_req_rw;
    smem_addr_t   ds_req_addr;
    smem_byteen_t ds_req_byteen;
    smem_data_t   ds_req_data;
    mem_tag_t     ds_req_tag;
    logic         ds_req_ready;
    logic         ds_rsp_valid;
    smem_data_t   ds_rsp_data;
    mem_tag_t     ds_rsp_tag;
    logic         ds_rsp_ready;

    // Arbiter to bank
    logic         mem_req_valid;
    logic         mem_req_rw;
    smem_addr_t   mem_req_addr;
    smem_byteen_t mem_req_byteen;
    smem_data_t   mem_req_data;
    mem_tag_t     mem_req_tag;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    smem_data_t   mem_rsp_data;
    mem_tag_t     mem_rsp_tag;
    logic         mem_rsp_ready;

    dxa_smem_downsize u_downsize (
        .clk            (clk),
        .reset          (reset),
        .dxa_req_valid  (dxa_req_valid),
        .dxa_req_rw     (dxa_req_rw),
        .dxa_req_addr   (dxa_req_addr),
        .dxa_req_byteen (dxa_req_byteen),
        .dxa_req_data   (dxa_req_data),
        .dxa_req_tag    (dxa_req_tag),
        .dxa_req_ready  (dxa_req_ready),
        .dxa_rsp_valid  (dxa_rsp_valid),
        .dxa_rsp_data   (dxa_rsp_data),
        .dxa_rsp_tag    (dxa_rsp_tag),
        .dxa_rsp_ready  (dxa_rsp_ready),
        .ds_req_valid   (ds_req_valid),
        .ds_req_rw      (ds_req_rw),
        .ds_req_addr    (ds_req_addr),
        .ds_req_byteen  (ds_req_byteen),
        .ds_req_data    (ds_req_data),
        .ds_req_tag     (ds_req_tag),
        .ds_req_ready   (ds_req_ready),
        .ds_rsp_valid   (ds_rsp_valid),
        .ds_rsp_data    (ds_rsp_data),
        .ds_rsp_tag     (ds_rsp_tag),
        .ds_rsp_ready   (ds_rsp_ready)
    );

    smem_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .ds_req_valid   (ds_req_valid),
        .ds_req_rw      (ds_req_rw),
        .ds_req_addr    (ds_req_addr),
        .ds_req_byteen  (ds_req_byteen),
        .ds_req_data    (ds_req_data),
        .ds_req_tag     (ds_req_tag),
        .ds_req_ready   (ds_req_ready),
        .ds_rsp_valid   (ds_rsp_valid),
        .ds_rsp_data    (ds_rsp_data),
        .ds_rsp_tag     (ds_rsp_tag),
        .ds_rsp_ready   (ds_rsp_ready),
        .lsu_req_valid  (lsu_req_valid),
        .lsu_req_rw     (lsu_req_rw),
        .lsu_req_addr   (lsu_req_addr),
        .lsu_req_byteen (lsu_req_byteen),
        .lsu_req_data   (lsu_req_data),
        .lsu_req_tag    (lsu_req_tag),
        .lsu_req_ready  (lsu_req_ready),
        .lsu_rsp_valid  (lsu_rsp_valid),
        .lsu_rsp_data   (lsu_rsp_data),
        .lsu_rsp_tag    (lsu_rsp_tag),
        .lsu_rsp_ready  (lsu_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    smem_bank u_bank (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag),
        .mem_rsp_ready  (mem_rsp_ready)
    );

endmodule

// File: verif/smem_shadow_model.sv
// Expected memory contents

`include "dxa_smem_settings.svh"

module smem_shadow_model import dxa_smem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    smem_data_t words [`SMEM_DEPTH];
    logic       known [`SMEM_DEPTH];

    initial begin
        for (int i = 0; i < `SMEM_DEPTH; i++) begin
            known[i] = 1'b0;
        end
    end

    // Only the enabled bytes change, the rest keep their old value
    function automatic void write_word(input smem_addr_t addr, input smem_byteen_t byteen,
                                       input smem_data_t data);
        for (int b = 0; b < `SMEM_WORD_BYTES; b++) begin
            if (byteen[b]) begin
                words[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        known[addr] = 1'b1;
    endfunction

    // A word never written has no defined value
    function automatic smem_data_t read_word(input smem_addr_t addr);
        if (!known[addr]) begin
            return 'x;
        end
        return words[addr];
    endfunction

endmodule

// File: verif/dxa_smem_tb.sv
// Shared memory testbench

module dxa_smem_tb import dxa_smem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_CYCLES = 40;

    logic         clk;
    logic         reset;
    logic         dxa_req_valid, dxa_req_rw, dxa_req_ready;
    dxa_addr_t    dxa_req_addr;
    dxa_byteen_t  dxa_req_byteen;
    dxa_data_t    dxa_req_data;
    mem_tag_t     dxa_req_tag;
    logic         dxa_rsp_valid, dxa_rsp_ready;
    dxa_data_t    dxa_rsp_data;
    mem_tag_t     dxa_rsp_tag;
    logic         lsu_req_valid, lsu_req_rw, lsu_req_ready;
    smem_addr_t   lsu_req_addr;
    smem_byteen_t lsu_req_byteen;
    smem_data_t   lsu_req_data;
    mem_tag_t     lsu_req_tag;
    logic         lsu_rsp_valid, lsu_rsp_ready;
    smem_data_t   lsu_rsp_data;
    mem_tag_t     lsu_rsp_tag;
    int           errors;
    int           checks;
    int           tests;
    int           seed;

    dxa_smem_top UUT (.*);

    smem_shadow_model shadow ();

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timed out after %0d cycles waiting for %s", WAIT_CYCLES, what);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%-16s %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    // All bus tasks start and end 5 ns after a rising edge
    task automatic send_lsu(input logic rw, input smem_addr_t addr, input smem_byteen_t be,
                            input smem_data_t data, input mem_tag_t tag);
        logic done;
        done = 1'b0;
        lsu_req_valid  = 1'b1;
        lsu_req_rw     = rw;
        lsu_req_addr   = addr;
        lsu_req_byteen = be;
        lsu_req_data   = data;
        lsu_req_tag    = tag;
        for (int i = 0; i < WAIT_CYCLES && !done; i++) begin
            @(negedge clk);
            done = lsu_req_ready;
            @(posedge clk);
            #5;
        end
        lsu_req_valid = 1'b0;
        if (!done) report_timeout("lsu request to be accepted");
    endtask

    task automatic recv_lsu(input smem_data_t exp_data, input mem_tag_t exp_tag);
        logic done;
        done = 1'b0;
        for (int i = 0; i < WAIT_CYCLES && !done; i++) begin
            @(negedge clk);
            if (lsu_rsp_valid && lsu_rsp_ready) begin
                done = 1'b1;
                check("lsu_rsp_data", lsu_rsp_data, exp_data);
                check("lsu_rsp_tag", lsu_rsp_tag, exp_tag);
            end
            @(posedge clk);
            #5;
        end
        if (!done) report_timeout("lsu read response");
    endtask

    task automatic send_dxa(input logic rw, input dxa_addr_t addr, input dxa_byteen_t be,
                            input dxa_data_t data, input mem_tag_t tag);
        logic done;
        done = 1'b0;
        dxa_req_valid  = 1'b1;
        dxa_req_rw     = rw;
        dxa_req_addr   = addr;
        dxa_req_byteen = be;
        dxa_req_data   = data;
        dxa_req_tag    = tag;
        for (int i = 0; i < WAIT_CYCLES && !done; i++) begin
            @(negedge clk);
            done = dxa_req_ready;
            @(posedge clk);
            #5;
        end
        dxa_req_valid = 1'b0;
        if (!done) report_timeout("dxa request to be accepted");
    endtask

    task automatic recv_dxa(input dxa_data_t exp_data, input mem_tag_t exp_tag);
        logic done;
        done = 1'b0;
        for (int i = 0; i < WAIT_CYCLES && !done; i++) begin
            @(negedge clk);
            if (dxa_rsp_valid && dxa_rsp_ready) begin
                done = 1'b1;
                check("dxa_rsp_data", dxa_rsp_data, exp_data);
                check("dxa_rsp_tag", dxa_rsp_tag, exp_tag);
            end
            @(posedge clk);
            #5;
        end
        if (!done) report_timeout("dxa read response");
    endtask

    task automatic lsu_write(input smem_addr_t addr, input smem_byteen_t be,
                             input smem_data_t data);
        send_lsu(1'b1, addr, be, data, mem_tag_t'($urandom));
        shadow.write_word(addr, be, data);
    endtask

    task automatic lsu_read(input smem_addr_t addr);
        mem_tag_t tag;
        tag = $urandom;
        send_lsu(1'b0, addr, '1, '0, tag);
        recv_lsu(shadow.read_word(addr), tag);
    endtask

    // Other lanes carry random data that must not reach the bank
    task automatic dxa_write(input smem_addr_t addr, input smem_data_t word);
        dxa_data_t wide;
        lane_idx_t lane;
        lane = addr[1:0];
        wide = {$urandom, $urandom, $urandom, $urandom};
        wide[lane*32 +: 32] = word;
        send_dxa(1'b1, addr[9:2], 16'hF << (lane * 4), wide, mem_tag_t'($urandom));
        shadow.write_word(addr, 4'hF, word);
    endtask

    task automatic dxa_read(input smem_addr_t addr);
        mem_tag_t  tag;
        lane_idx_t lane;
        tag = $urandom;
        lane = addr[1:0];
        send_dxa(1'b0, addr[9:2], 16'hF << (lane * 4), '0, tag);
        recv_dxa(dxa_data_t'(shadow.read_word(addr)) << (lane * 32), tag);
    endtask

    // The repeated wide read is held off until the first response has gone
    task automatic dxa_read_twice(input smem_addr_t addr);
        mem_tag_t    tag;
        dxa_byteen_t be;
        dxa_data_t   exp_data;
        tag = $urandom;
        be = 16'hF << (addr[1:0] * 4);
        exp_data = dxa_data_t'(shadow.read_word(addr)) << (addr[1:0] * 32);
        send_dxa(1'b0, addr[9:2], be, '0, tag);
        dxa_req_valid = 1'b1;
        @(negedge clk);
        check("dxa_rsp_valid", dxa_rsp_valid, 1'b1);
        check("dxa_rsp_data", dxa_rsp_data, exp_data);
        check("dxa_rsp_tag", dxa_rsp_tag, tag);
        check("dxa_req_ready", dxa_req_ready, 1'b0);
        @(posedge clk);
        #5;
        send_dxa(1'b0, addr[9:2], be, '0, tag);
        recv_dxa(exp_data, tag);
    endtask

    task automatic reset_state();
        int errs;
        errs = errors;
        repeat (8) begin
            @(posedge clk);
            #5;
            check("dxa_rsp_valid", dxa_rsp_valid, 1'b0);
            check("lsu_rsp_valid", lsu_rsp_valid, 1'b0);
        end
        reset = 1'b0;
        @(negedge clk);
        check("dxa_rsp_valid", dxa_rsp_valid, 1'b0);
        check("lsu_rsp_valid", lsu_rsp_valid, 1'b0);
        @(posedge clk);
        #5;
        end_test("reset", errs);
    endtask

    task automatic wide_write_narrow_read();
        int         errs;
        smem_addr_t addr;
        errs = errors;
        for (int lane = 0; lane < 4; lane++) begin
            addr = {dxa_addr_t'($urandom), lane_idx_t'(lane)};
            dxa_write(addr, $urandom);
            lsu_read(addr);
        end
        end_test("wide write", errs);
    endtask

    task automatic narrow_write_wide_read();
        int         errs;
        smem_addr_t addr;
        errs = errors;
        for (int i = 0; i < 4; i++) begin
            addr = $urandom;
            lsu_write(addr, 4'hF, $urandom);
            dxa_read(addr);
        end
        dxa_read_twice(addr);
        end_test("narrow write", errs);
    endtask

    task automatic partial_byte_writes();
        int         errs;
        smem_addr_t addr;
        errs = errors;
        for (int i = 0; i < 8; i++) begin
            addr = $urandom;
            lsu_write(addr, 4'hF, $urandom);
            lsu_write(addr, smem_byteen_t'($urandom), $urandom);
            lsu_read(addr);
        end
        end_test("partial bytes", errs);
    endtask

    task automatic contended_reads();
        int         errs;
        smem_addr_t addr_a;
        smem_addr_t addr_b;
        errs = errors;
        for (int i = 0; i < 20; i++) begin
            addr_a = $urandom;
            addr_b = $urandom;
            lsu_write(addr_a, 4'hF, $urandom);
            lsu_write(addr_b, 4'hF, $urandom);
            fork
                lsu_read(addr_a);
                dxa_read(addr_b);
            join
        end
        end_test("contention", errs);
    endtask

    task automatic held_response();
        int         errs;
        smem_addr_t addr_a;
        smem_addr_t addr_b;
        mem_tag_t   tag_a;
        mem_tag_t   tag_b;
        errs = errors;
        addr_a = $urandom;
        addr_b = $urandom;
        tag_a = $urandom;
        tag_b = $urandom;
        lsu_write(addr_a, 4'hF, $urandom);
        lsu_write(addr_b, 4'hF, $urandom);
        lsu_rsp_ready = 1'b0;
        send_lsu(1'b0, addr_a, 4'hF, '0, tag_a);
        // Second read waits behind the held response
        lsu_req_valid  = 1'b1;
        lsu_req_rw     = 1'b0;
        lsu_req_addr   = addr_b;
        lsu_req_tag    = tag_b;
        repeat (5) begin
            @(negedge clk);
            check("lsu_rsp_valid", lsu_rsp_valid, 1'b1);
            check("lsu_rsp_data", lsu_rsp_data, shadow.read_word(addr_a));
            check("lsu_rsp_tag", lsu_rsp_tag, tag_a);
            check("lsu_req_ready", lsu_req_ready, 1'b0);
            @(posedge clk);
            #5;
        end
        lsu_rsp_ready = 1'b1;
        @(negedge clk);
        check("lsu_rsp_valid", lsu_rsp_valid, 1'b1);
        check("lsu_req_ready", lsu_req_ready, 1'b1);
        @(posedge clk);
        #5;
        lsu_req_valid = 1'b0;
        recv_lsu(shadow.read_word(addr_b), tag_b);
        end_test("back-pressure", errs);
    endtask

    initial begin
        seed = $urandom(46);
        errors = 0;
        checks = 0;
        tests = 0;
        clk = 1'b0;
        reset = 1'b1;
        dxa_req_valid = 1'b0;
        dxa_req_rw = 1'b0;
        dxa_req_addr = '0;
        dxa_req_byteen = '0;
        dxa_req_data = '0;
        dxa_req_tag = '0;
        dxa_rsp_ready = 1'b1;
        lsu_req_valid = 1'b0;
        lsu_req_rw = 1'b0;
        lsu_req_addr = '0;
        lsu_req_byteen = '0;
        lsu_req_data = '0;
        lsu_req_tag = '0;
        lsu_rsp_ready = 1'b1;

        reset_state();
        wide_write_narrow_read();
        narrow_write_wide_read();
        partial_byte_writes();
        contended_reads();
        held_response();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dxa_smem.f
+incdir+include
verilog/dxa_smem_pkg.sv
verilog/dxa_smem_downsize.sv
verilog/smem_arbiter.sv
verilog/smem_bank.sv
verilog/dxa_smem_top.sv
verif/smem_shadow_model.sv
verif/dxa_smem_tb.sv

// File: Bender.yml
package:
  name: dxa_smem

sources:
  - include_dirs:
      - include
    files:
      - verilog/dxa_smem_pkg.sv
      - verilog/dxa_smem_downsize.sv
      - verilog/smem_arbiter.sv
      - verilog/smem_bank.sv
      - verilog/dxa_smem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/smem_shadow_model.sv
      - verif/dxa_smem_tb.sv
